/* verilog.f */
+incdir+common
+incdir+tb
common/dot_matrix_pkg.sv
common/dot_matrix_if.sv
verilog/input_sync.sv
dot_matrix/row_scanner.sv
dot_matrix/glyph_rom.sv
dot_matrix/row_driver.sv
verilog/dot_matrix_top.sv
tb/tb_dot_matrix.sv

/* Makefile */
# Verilator build for the dot-matrix driver

VERILATOR  ?= verilator
FILELIST   ?= verilog.f
RTL_TOP    ?= dot_matrix_top
TB_TOP     ?= tb_dot_matrix
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert --timescale 1ns/1ns
LINT_FLAGS ?=
SIM_FLAGS  ?= -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) \
		--top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) \
		--top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation passed" $(LOG); then \
		echo "verdict: pass"; \
	else \
		echo "verdict: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_glyph_model.svh */
`ifndef TB_GLYPH_MODEL_SVH
`define TB_GLYPH_MODEL_SVH

// green art per glyph, row 0 in the top byte
function automatic logic [63:0] green_frame(input logic [3:0] g);
    logic [63:0] f;
    case (g)
        4'd0:    f = 64'h0000_183C_3C18_0000;
        4'd1:    f = 64'h0000_387C_7C38_0000;
        4'd2:    f = 64'h0000_3C7E_7E3C_0000;
        4'd3:    f = 64'h003C_7E7E_7E7E_3C00;
        4'd4:    f = 64'h3C7E_FFFF_FFFF_7E3C;
        4'd5:    f = 64'hFFFF_FFFF_FFFF_FFFF; // full panel
        4'd6:    f = 64'hC3E3_F1E3_C7E7_F7FB;
        4'd7:    f = 64'h0001_81C3_83C7_E7F3;
        4'd8:    f = 64'h0038_445A_4A32_C438;
        4'd9:    f = 64'h0000_60FC_3F3E_1C00;
        4'd10:   f = 64'h0000_183C_7E7E_2400;
        default: f = 64'h0; // 11 and 12..15 show no green
    endcase
    return f;
endfunction

// glyphs that carry red art of their own
function automatic logic [63:0] red_frame(input logic [3:0] g);
    logic [63:0] f;
    case (g)
        4'd8:    f = 64'h0038_445A_4A32_C438;
        4'd11:   f = 64'hE060_E030_3133_3E1C;
        default: f = 64'h0;
    endcase
    return f;
endfunction

// expected {green, red} of one row
function automatic logic [15:0] glyph_model(
    input logic [3:0] g,
    input logic [2:0] r,
    input logic       hot
);
    logic [63:0] gf;
    logic [63:0] rf;
    logic [7:0]  green;
    logic [7:0]  red;
    gf = green_frame(g);
    rf = red_frame(g);
    green = gf[8 * (7 - r) +: 8];
    if (g == 4'd8 || g == 4'd11)
        red = rf[8 * (7 - r) +: 8];
    else if (g == 4'd6 || g == 4'd7 || g == 4'd9)
        red = green; // follows green at any temperature
    else if (hot && g <= 4'd5)
        red = green;
    else
        red = 8'h00;
    return {green, red};
endfunction

`endif

/* tb/tb_dot_matrix.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dot_matrix_params.svh"

module tb_dot_matrix;

    localparam int TIMEOUT = 200;

    logic       clk = 1'b0;
    logic       rst;
    logic       st;
    logic       temp;
    logic [3:0] num;
    logic [7:0] row;
    logic [7:0] colg;
    logic [7:0] colr;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int checks_done = 0;
    int stable_cnt = 0;
    logic [5:0] last_in = '0;

    `include "tb_glyph_model.svh"

    dot_matrix_top UUT (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .temp (temp),
        .num  (num),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] want);
        if (got !== want)
        begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, want);
            errors = errors + 1;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%0t ns: %s", $time, why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic end_test(input string name, input int err_mark);
        tests_run = tests_run + 1;
        if (errors != err_mark)
        begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        else
            $display("test %0d %s: ok", tests_run, name);
    endtask

    // position of the single low row line or -1
    function automatic int zero_index(input logic [7:0] r);
        int idx;
        int zeros;
        idx = -1;
        zeros = 0;
        for (int i = 0; i < 8; i++)
        begin
            if (r[i] === 1'b0)
            begin
                zeros = zeros + 1;
                idx = i;
            end
        end
        return (zeros == 1) ? idx : -1;
    endfunction

    // compare settled rows against the model
    always @(negedge clk)
    begin : compare_rows
        logic [15:0] exp_bits;
        int k;
        if (rst || {st, temp, num} != last_in)
            stable_cnt = 0;
        else if (stable_cnt < 1000)
            stable_cnt = stable_cnt + 1;
        last_in = {st, temp, num};
        k = zero_index(row);
        if (!rst && stable_cnt >= `DM_SYNC_STAGES + 3 && k >= 0)
        begin
            exp_bits = glyph_model(num, 3'(k), temp);
            check_value("colg", colg, exp_bits[15:8]);
            check_value("colr", colr, exp_bits[7:0]);
            checks_done = checks_done + 1;
        end
    end

    task automatic check_blank();
        check_value("row", row, 8'hff);
        check_value("colg", colg, 8'h00);
        check_value("colr", colr, 8'h00);
    endtask

    task automatic wait_checks(input int n);
        int start;
        int t;
        start = checks_done;
        t = 0;
        while (checks_done - start < n && t < TIMEOUT)
        begin
            @(posedge clk);
            t = t + 1;
        end
        if (checks_done - start < n)
            abort_run("timed out waiting for checked rows");
    endtask

    task automatic wait_blank();
        int t;
        t = 0;
        @(negedge clk);
        while (!(row === 8'hff && colg === 8'h00 && colr === 8'h00) && t < TIMEOUT)
        begin
            @(negedge clk);
            t = t + 1;
        end
        if (!(row === 8'hff && colg === 8'h00 && colr === 8'h00))
            abort_run("outputs never blanked after st went low");
    endtask

    // scan must start at row 0 and step by one
    task automatic check_row_sequence(input int cycles);
        int t;
        logic [7:0] exp_row;
        t = 0;
        @(negedge clk);
        while (row === 8'hff && t < TIMEOUT)
        begin
            @(negedge clk);
            t = t + 1;
        end
        if (row === 8'hff)
            abort_run("row scan never started");
        for (int c = 0; c < cycles; c++)
        begin
            exp_row = 8'hff;
            exp_row[c % 8] = 1'b0; // row lines are active low
            check_value("row", row, exp_row);
            @(negedge clk);
        end
    endtask

    task automatic show_glyph(input logic [3:0] g, input logic hot);
        @(posedge clk);
        num  <= g;
        temp <= hot;
        wait_checks(8); // one full frame
    endtask

    initial
    begin
        int unsigned seed_val;
        int err_mark;
        rst  = 1'b1;
        st   = 1'b0;
        temp = 1'b0;
        num  = '0;
        seed_val = $urandom(32'h46f9);
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        err_mark = errors;
        repeat (12)
        begin
            @(negedge clk);
            check_blank();
        end
        end_test("idle after reset", err_mark);

        err_mark = errors;
        @(posedge clk);
        num  <= 4'd5;
        temp <= 1'b1;
        st   <= 1'b1;
        check_row_sequence(24);
        end_test("row scan order", err_mark);

        err_mark = errors;
        for (int g = 0; g < 16; g++)
            show_glyph(4'(g), 1'b1);
        end_test("glyph sweep, temp high", err_mark);

        err_mark = errors;
        for (int g = 0; g < 16; g++)
            show_glyph(4'(g), 1'b0);
        end_test("glyph sweep, temp low", err_mark);

        err_mark = errors;
        for (int i = 0; i < 40; i++)
        begin
            @(posedge clk);
            num  <= 4'($urandom % 16);
            temp <= 1'($urandom % 2);
            wait_checks(1 + int'($urandom % 10));
        end
        end_test("random glyph and temp", err_mark);

        err_mark = errors;
        @(posedge clk);
        st <= 1'b0;
        wait_blank();
        repeat (10)
        begin
            @(negedge clk);
            check_blank();
        end
        @(posedge clk);
        st <= 1'b1;
        check_row_sequence(16);
        end_test("blank and restart", err_mark);

        $display("tests %0d, failed %0d, rows checked %0d, errors %0d",
                 tests_run, tests_failed, checks_done, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/dot_matrix_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dot_matrix_top (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       st,
    input  wire logic                       temp,
    input  wire dot_matrix_pkg::glyph_id_t  num,
    output      logic [7:0]                 row,
    output      dot_matrix_pkg::col_bits_t  colg,
    output      dot_matrix_pkg::col_bits_t  colr
);

    scan_if  scan ();
    pixel_if pix ();

    input_sync u_input_sync (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .temp (temp),
        .num  (num),
        .scan (scan.source)
    );

    row_scanner u_row_scanner (
        .clk  (clk),
        .rst  (rst),
        .scan (scan.counter)
    );

    glyph_rom u_glyph_rom (
        .clk  (clk),
        .rst  (rst),
        .scan (scan.lookup),
        .pix  (pix.source)
    );

    row_driver u_row_driver (
        .clk  (clk),
        .rst  (rst),
        .pix  (pix.sink),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

endmodule

`default_nettype wire

/* dot_matrix/row_driver.sv */
`timescale 1ns/1ns
`default_nettype none

module row_driver (
    input  wire logic                       clk,
    input  wire logic                       rst,
    pixel_if.sink                           pix,
    output      logic [7:0]                 row,
    output      dot_matrix_pkg::col_bits_t  colg,
    output      dot_matrix_pkg::col_bits_t  colr
);

    logic [7:0] row_sel;

    // active-low one-hot with row 0 on bit 0
    assign row_sel = ~(8'b0000_0001 << pix.row_idx);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= 8'hff;
            colg <= '0;
            colr <= '0;
        end
        else if (!pix.valid)
        begin
            row  <= 8'hff; // blanked
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= row_sel;
            colg <= pix.green;
            colr <= pix.red;
        end
    end

    // an active row is followed by the next row while the scan runs
    a_row_step: assert property (
        @(posedge clk) disable iff (rst)
        (row != 8'hff && pix.valid) |=> (row == $past({row[6:0], row[7]}))
    );

endmodule

`default_nettype wire

/* dot_matrix/glyph_rom.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dot_matrix_params.svh"

module glyph_rom (
    input  wire logic clk,
    input  wire logic rst,
    scan_if.lookup    scan,
    pixel_if.source   pix
);

    dot_matrix_pkg::col_bits_t green_d;
    dot_matrix_pkg::col_bits_t red_d;
    logic                      valid_q;

    function automatic dot_matrix_pkg::col_bits_t green_of(
        input dot_matrix_pkg::glyph_id_t g,
        input dot_matrix_pkg::row_idx_t  r
    );
        dot_matrix_pkg::col_bits_t bits;
        bits = '0;
        case (g)
            4'd0:
                case (r)
                    3'd2, 3'd5: bits = 8'b0001_1000;
                    3'd3, 3'd4: bits = 8'b0011_1100;
                    default:    bits = '0;
                endcase
            4'd1:
                case (r)
                    3'd2, 3'd5: bits = 8'b0011_1000;
                    3'd3, 3'd4: bits = 8'b0111_1100;
                    default:    bits = '0;
                endcase
            4'd2:
                case (r)
                    3'd2, 3'd5: bits = 8'b0011_1100;
                    3'd3, 3'd4: bits = 8'b0111_1110;
                    default:    bits = '0;
                endcase
            4'd3:
                case (r)
                    3'd1, 3'd6:             bits = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: bits = 8'b0111_1110;
                    default:                bits = '0;
                endcase
            4'd4:
                case (r)
                    3'd0, 3'd7: bits = 8'b0011_1100;
                    3'd1, 3'd6: bits = 8'b0111_1110;
                    default:    bits = 8'b1111_1111;
                endcase
            4'd5: bits = 8'b1111_1111; // full panel
            4'd6:
                case (r)
                    3'd0: bits = 8'b1100_0011;
                    3'd1: bits = 8'b1110_0011;
                    3'd2: bits = 8'b1111_0001;
                    3'd3: bits = 8'b1110_0011;
                    3'd4: bits = 8'b1100_0111;
                    3'd5: bits = 8'b1110_0111;
                    3'd6: bits = 8'b1111_0111;
                    default: bits = 8'b1111_1011;
                endcase
            4'd7:
                case (r)
                    3'd1: bits = 8'b0000_0001;
                    3'd2: bits = 8'b1000_0001;
                    3'd3: bits = 8'b1100_0011;
                    3'd4: bits = 8'b1000_0011;
                    3'd5: bits = 8'b1100_0111;
                    3'd6: bits = 8'b1110_0111;
                    3'd7: bits = 8'b1111_0011;
                    default: bits = '0;
                endcase
            4'd8:
                case (r)
                    3'd1: bits = 8'b0011_1000;
                    3'd2: bits = 8'b0100_0100;
                    3'd3: bits = 8'b0101_1010;
                    3'd4: bits = 8'b0100_1010;
                    3'd5: bits = 8'b0011_0010;
                    3'd6: bits = 8'b1100_0100;
                    3'd7: bits = 8'b0011_1000;
                    default: bits = '0;
                endcase
            4'd9:
                case (r)
                    3'd2: bits = 8'b0110_0000;
                    3'd3: bits = 8'b1111_1100;
                    3'd4: bits = 8'b0011_1111;
                    3'd5: bits = 8'b0011_1110;
                    3'd6: bits = 8'b0001_1100;
                    default: bits = '0;
                endcase
            4'd10:
                case (r)
                    3'd2:       bits = 8'b0001_1000;
                    3'd3:       bits = 8'b0011_1100;
                    3'd4, 3'd5: bits = 8'b0111_1110;
                    3'd6:       bits = 8'b0010_0100;
                    default:    bits = '0;
                endcase
            default: bits = '0; // 11 is red only
        endcase
        return bits;
    endfunction

    // red-only bitmap of glyph 11
    function automatic dot_matrix_pkg::col_bits_t red11_of(input dot_matrix_pkg::row_idx_t r);
        dot_matrix_pkg::col_bits_t bits;
        case (r)
            3'd0: bits = 8'b1110_0000;
            3'd1: bits = 8'b0110_0000;
            3'd2: bits = 8'b1110_0000;
            3'd3: bits = 8'b0011_0000;
            3'd4: bits = 8'b0011_0001;
            3'd5: bits = 8'b0011_0011;
            3'd6: bits = 8'b0011_1110;
            default: bits = 8'b0001_1100;
        endcase
        return bits;
    endfunction

    always_comb
    begin
        if (scan.glyph < 4'(`DM_GLYPHS))
            green_d = green_of(scan.glyph, scan.row_idx);
        else
            green_d = '0;

        case (scan.glyph)
            4'd8:                      red_d = green_of(4'd8, scan.row_idx); // own bitmap in the same shape
            4'd11:                     red_d = red11_of(scan.row_idx);
            4'd6, 4'd7, 4'd9:          red_d = green_d;
            4'd0, 4'd1, 4'd2, 4'd3,
            4'd4, 4'd5:                red_d = scan.temp_hot ? green_d : '0;
            default:                   red_d = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            valid_q <= 1'b0;
        else
            valid_q <= scan.enable;
    end

    always_ff @(posedge clk)
    begin
        pix.row_idx <= scan.row_idx;
        pix.green   <= scan.enable ? green_d : '0;
        pix.red     <= scan.enable ? red_d : '0;
    end

    assign pix.valid = valid_q;

    // red only lights where green does, apart from the glyphs with red art
    a_red_subset: assert property (
        @(posedge clk) disable iff (rst)
        !($past(scan.glyph) inside {4'd8, 4'd11}) |-> ((pix.red & ~pix.green) == '0)
    );

endmodule

`default_nettype wire

/* dot_matrix/row_scanner.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dot_matrix_params.svh"

module row_scanner (
    input  wire logic clk,
    input  wire logic rst,
    scan_if.counter   scan
);

    localparam dot_matrix_pkg::row_idx_t LAST_ROW = 3'(`DM_ROWS - 1);

    dot_matrix_pkg::row_idx_t row_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_q <= '0;
        else if (!scan.enable)
            row_q <= '0; // restart at the top on every enable
        else if (row_q == LAST_ROW)
            row_q <= '0;
        else
            row_q <= row_q + 3'd1;
    end

    assign scan.row_idx = row_q;

    // counter wraps 7 -> 0 through the 3-bit width
    a_row_step: assert property (
        @(posedge clk) disable iff (rst)
        scan.enable |=> (row_q == $past(row_q) + 3'd1)
    );

endmodule

`default_nettype wire

/* verilog/input_sync.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dot_matrix_params.svh"

module input_sync (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      st,
    input  wire logic                      temp,
    input  wire dot_matrix_pkg::glyph_id_t num,
    scan_if.source                         scan
);

    localparam int N = `DM_SYNC_STAGES;

    logic [N-1:0] st_sr;
    logic [N-1:0] temp_sr;
    dot_matrix_pkg::glyph_id_t [N-1:0] num_sr; // same depth keeps num aligned with st

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            st_sr   <= '0;
            temp_sr <= '0;
            num_sr  <= '0;
        end
        else
        begin
            st_sr   <= {st_sr[N-2:0], st};
            temp_sr <= {temp_sr[N-2:0], temp};
            num_sr  <= {num_sr[N-2:0], num};
        end
    end

    assign scan.enable   = st_sr[N-1];
    assign scan.temp_hot = temp_sr[N-1];

    // no stale glyph while blanked
    assign scan.glyph = st_sr[N-1] ? num_sr[N-1] : '0;

endmodule

`default_nettype wire

/* common/dot_matrix_if.sv */
`timescale 1ns/1ns
`default_nettype none

// synchronized controls plus the current scan row
interface scan_if;
    logic                    enable;
    logic                    temp_hot;
    dot_matrix_pkg::glyph_id_t glyph;
    dot_matrix_pkg::row_idx_t  row_idx;

    modport source (output enable, output temp_hot, output glyph);
    modport counter (input enable, output row_idx);
    modport lookup (input enable, input temp_hot, input glyph, input row_idx);
endinterface

// one row of pixel data per clock, no back-pressure
interface pixel_if;
    logic                     valid;
    dot_matrix_pkg::row_idx_t  row_idx;
    dot_matrix_pkg::col_bits_t green;
    dot_matrix_pkg::col_bits_t red;

    modport source (output valid, output row_idx, output green, output red);
    modport sink (input valid, input row_idx, input green, input red);
endinterface

`default_nettype wire

/* common/dot_matrix_pkg.sv */
`default_nettype none

package dot_matrix_pkg;

    // glyph number, 0..11 defined, 12..15 show nothing
    typedef logic [3:0] glyph_id_t;

    // scanned row, 0 is the top row
    typedef logic [2:0] row_idx_t;

    // one row of one color, bit 7 = leftmost column, 1 = lit
    typedef logic [7:0] col_bits_t;

endpackage

`default_nettype wire

/* common/dot_matrix_params.svh */
`ifndef DOT_MATRIX_PARAMS_SVH
`define DOT_MATRIX_PARAMS_SVH

// rows scanned per frame
`define DM_ROWS 8

// glyphs with a bitmap in the table
`define DM_GLYPHS 12

// flops per synchronizer chain
`define DM_SYNC_STAGES 2

`endif
